// ==== fetch_stimulus.txt ====
# cmd op1 op2 op3 expected_pc, all hex
# RUN n, BUSY k (ff random), STALL n, BRJ, TRAP, BOTH trap brj, UPDATE pc target taken, MISALIGN
RUN 0 0 0 80000000
RUN 3 0 0 80000010
BUSY 2 0 0 80000014
RUN 2 0 0 80000020
STALL 5 0 0 80000024
BUSY ff 0 0 80000028
RUN 3 0 0 80000038
STALL 3 0 0 8000003c
BUSY 0 0 0 80000040
BRJ 80001000 0 0 80001000
RUN 2 0 0 8000100c
TRAP 80000100 0 0 80000100
BOTH 80000200 80000300 0 80000200
UPDATE 80002000 80003000 1 80003000
RUN 1 0 0 80003008
UPDATE 80002000 80003000 0 80002004
MISALIGN 80004002 0 0 80004002
RUN 1 0 0 8000400a
BUSY 3 0 0 8000400e
BRJ 80000400 0 0 80000400
RUN 2 0 0 8000040c

// ==== build.f ====
+incdir+.
fetch_pkg.sv
fetch_control.sv
branch_predictor.sv
fetch_stage.sv
fetch_top.sv
fetch_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing -f build.f --top-module fetch_tb -o fetch_sim
	./obj_dir/fetch_sim | awk '{ print } /Finished with no errors/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

// ==== fetch_tb.sv ====
`timescale 1ns/1ps
`include "fetch_defines.svh"

module fetch_tb import fetch_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 200;
    localparam logic [31:0] MEM_KEY = 32'h13579bdf;

    logic       CLK;
    logic       nRST;
    word_t      imem_rdata;
    logic       imem_busy;
    word_t      imem_addr;
    logic       imem_ren;
    redirect_t  redirect;
    bp_update_t bp_update;
    logic       ex_stall;
    fetch_ex_t  fetch_ex_out;

    int unsigned busy_cnt;
    int unsigned wait_cfg;
    logic        random_mode;
    logic        stall_at_edge;
    logic        have_prev;
    fetch_ex_t   prev_ex;
    fetch_ex_t   entries[$];
    int          errors;
    int          checks;
    int          step;
    word_t       last_pc;

    fetch_top uut (
        .CLK          (CLK),
        .nRST         (nRST),
        .imem_rdata   (imem_rdata),
        .imem_busy    (imem_busy),
        .imem_addr    (imem_addr),
        .imem_ren     (imem_ren),
        .redirect     (redirect),
        .bp_update    (bp_update),
        .ex_stall     (ex_stall),
        .fetch_ex_out (fetch_ex_out)
    );

    always #10 CLK = ~CLK;

    // Instruction memory whose word depends on every address bit
    assign imem_rdata = imem_addr ^ MEM_KEY;
    assign imem_busy  = (busy_cnt != 0);

    // Wait states start again after each accepted word
    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            busy_cnt <= 0;
        end else if (imem_ren && !imem_busy) begin
            busy_cnt <= random_mode ? ($urandom % 4) : wait_cfg;
        end else if (busy_cnt != 0) begin
            busy_cnt <= busy_cnt - 1;
        end
    end

    always @(posedge CLK) begin
        stall_at_edge = ex_stall;
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        checks++;
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: step %0d %s (got %h, expected %h)",
                     $time, step, msg, actual, expected);
            errors++;
        end
    endtask

    // Collect new entries and confirm the register holds while execute stalls
    always @(negedge CLK) begin
        if (nRST) begin
            if (stall_at_edge && have_prev) begin
                check_value(fetch_ex_out.pc, prev_ex.pc, "pc changed under stall");
                check_value(fetch_ex_out.instr, prev_ex.instr, "instr changed under stall");
                check_value({29'b0, fetch_ex_out.valid, fetch_ex_out.mal_insn,
                             fetch_ex_out.prediction},
                            {29'b0, prev_ex.valid, prev_ex.mal_insn, prev_ex.prediction},
                            "flags changed under stall");
                check_value({31'b0, imem_ren}, 32'd1, "ren dropped under stall");
            end else if (fetch_ex_out.valid) begin
                entries.push_back(fetch_ex_out);
            end
            prev_ex   = fetch_ex_out;
            have_prev = 1'b1;
        end
    end

    task automatic next_entry(output fetch_ex_t e);
        int cnt;
        cnt = 0;
        e   = '0;
        while (entries.size() == 0 && cnt < TIMEOUT_CYCLES) begin
            @(posedge CLK);
            cnt++;
        end
        if (entries.size() == 0) begin
            $display("Timeout in step %0d: no valid fetch_ex entry arrived", step);
            errors++;
        end else begin
            e = entries.pop_front();
            check_value(e.pc4, e.pc + 32'd4, "pc4");
            check_value(e.instr, e.pc ^ MEM_KEY, "instr");
            check_value({31'b0, e.mal_insn}, {31'b0, e.pc[1:0] != 2'b00}, "mal_insn");
        end
    endtask

    // One cycle of redirect and BTB write that drops the entries in flight
    task automatic send_redirect(input logic trap_en, input word_t trap_addr,
                                 input logic brj_en, input word_t brj_addr,
                                 input logic upd_en, input logic upd_taken);
        @(posedge CLK);
        redirect.insert_priv_pc  <= trap_en;
        redirect.priv_pc         <= trap_addr;
        redirect.brj_sel         <= brj_en;
        redirect.brj_addr        <= brj_addr;
        bp_update.update_en      <= upd_en;
        bp_update.update_pc      <= brj_addr;
        bp_update.update_target  <= trap_addr;
        bp_update.update_taken   <= upd_taken;
        @(posedge CLK);
        redirect  <= '0;
        bp_update <= '0;
        entries.delete();
    endtask

    initial begin
        integer      fd;
        integer      n;
        string       line;
        logic [63:0] cmd;
        word_t       op1;
        word_t       op2;
        word_t       op3;
        word_t       exp_pc;
        fetch_ex_t   e;

        void'($urandom(32'h17b1));
        CLK         = 1'b0;
        nRST        = 1'b0;
        redirect    = '0;
        bp_update   = '0;
        ex_stall    = 1'b0;
        wait_cfg    = 0;
        random_mode = 1'b0;
        have_prev   = 1'b0;
        errors      = 0;
        checks      = 0;
        step        = 0;
        last_pc     = `FETCH_RESET_PC - 32'd4;
        repeat (5) @(posedge CLK);
        nRST <= 1'b1;

        // One idle cycle without a read, then reads in FETCH
        @(negedge CLK);
        check_value({31'b0, imem_ren}, 32'd0, "ren in first cycle after reset");
        @(negedge CLK);
        check_value({31'b0, imem_ren}, 32'd1, "ren in FETCH after reset");
        @(posedge CLK);

        fd = $fopen("fetch_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open fetch_stimulus.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n == 0 || line.len() < 4 || line[0] == "#") begin
                    continue;
                end
                step++;
                n = $sscanf(line, "%s %h %h %h %h", cmd, op1, op2, op3, exp_pc);
                if (n != 5) begin
                    $display("Malformed stimulus line at step %0d", step);
                    errors++;
                    continue;
                end
                if (cmd == "RUN") begin
                    for (int i = 0; i < op1; i++) begin
                        next_entry(e);
                        last_pc = last_pc + 32'd4;
                        check_value(e.pc, last_pc, "sequential pc");
                    end
                end else if (cmd == "BUSY") begin
                    random_mode <= (op1 == 32'hff);
                    wait_cfg    <= op1;
                end else if (cmd == "STALL") begin
                    @(posedge CLK);
                    ex_stall <= 1'b1;
                    repeat (op1) @(posedge CLK);
                    ex_stall <= 1'b0;
                end else if (cmd == "BRJ" || cmd == "MISALIGN") begin
                    send_redirect(1'b0, '0, 1'b1, op1, 1'b0, 1'b0);
                end else if (cmd == "TRAP") begin
                    send_redirect(1'b1, op1, 1'b0, '0, 1'b0, 1'b0);
                end else if (cmd == "BOTH") begin
                    send_redirect(1'b1, op1, 1'b1, op2, 1'b0, 1'b0);
                end else if (cmd == "UPDATE") begin
                    // Write the BTB and jump to the branch itself
                    send_redirect(1'b0, op2, 1'b1, op1, 1'b1, op3[0]);
                    next_entry(e);
                    check_value(e.pc, op1, "branch pc");
                    check_value({31'b0, e.prediction}, {31'b0, op3[0]}, "prediction");
                end else begin
                    $display("Unknown stimulus command at step %0d", step);
                    errors++;
                    continue;
                end
                next_entry(e);
                check_value(e.pc, exp_pc, "next valid pc");
                if (cmd == "MISALIGN") begin
                    check_value({31'b0, e.mal_insn}, 32'd1, "misaligned flag");
                end
                last_pc = exp_pc;
            end
            $fclose(fd);
        end

        $display("Steps: %0d, checks: %0d, errors: %0d", step, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; (
    input  logic       CLK,
    input  logic       nRST,
    input  word_t      imem_rdata,
    input  logic       imem_busy,
    output word_t      imem_addr,
    output logic       imem_ren,
    input  redirect_t  redirect,
    input  bp_update_t bp_update,
    input  logic       ex_stall,
    output fetch_ex_t  fetch_ex_out
);

    logic  pc_en;
    logic  if_ex_stall;
    logic  if_ex_flush;
    logic  predict_taken;
    word_t target_addr;
    word_t current_pc;

    fetch_control u_control (
        .CLK           (CLK),
        .nRST          (nRST),
        .imem_busy     (imem_busy),
        .ex_stall      (ex_stall),
        .redirect      (redirect),
        .predict_taken (predict_taken),
        .pc_en         (pc_en),
        .iren          (imem_ren),
        .if_ex_stall   (if_ex_stall),
        .if_ex_flush   (if_ex_flush)
    );

    branch_predictor u_predictor (
        .CLK           (CLK),
        .nRST          (nRST),
        .current_pc    (current_pc),
        .update        (bp_update),
        .predict_taken (predict_taken),
        .target_addr   (target_addr)
    );

    fetch_stage u_fetch (
        .CLK           (CLK),
        .nRST          (nRST),
        .pc_en         (pc_en),
        .if_ex_stall   (if_ex_stall),
        .if_ex_flush   (if_ex_flush),
        .redirect      (redirect),
        .predict_taken (predict_taken),
        .target_addr   (target_addr),
        .imem_rdata    (imem_rdata),
        .imem_addr     (imem_addr),
        .current_pc    (current_pc),
        .fetch_ex      (fetch_ex_out)
    );

endmodule

// ==== fetch_stage.sv ====
`timescale 1ns/1ps
`include "fetch_defines.svh"

module fetch_stage import fetch_pkg::*; (
    input  logic      CLK,
    input  logic      nRST,
    input  logic      pc_en,
    input  logic      if_ex_stall,
    input  logic      if_ex_flush,
    input  redirect_t redirect,
    input  logic      predict_taken,
    input  word_t     target_addr,
    input  word_t     imem_rdata,
    output word_t     imem_addr,
    output word_t     current_pc,
    output fetch_ex_t fetch_ex
);

    word_t pc;
    word_t pc4;
    word_t npc;
    word_t rdata_swapped;
    word_t instr;
    logic  mal_insn;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            pc <= `FETCH_RESET_PC;
        end else if (pc_en) begin
            pc <= npc;
        end
    end

    assign pc4 = pc + 32'd4;

    // Trap first, then resolved branch, then prediction
    assign npc = redirect.insert_priv_pc ? redirect.priv_pc
               : redirect.brj_sel        ? redirect.brj_addr
               : predict_taken           ? target_addr
               : pc4;

    assign imem_addr  = pc;
    assign current_pc = pc;

    // Byte order of the instruction bus
    assign rdata_swapped = {imem_rdata[7:0], imem_rdata[15:8],
                            imem_rdata[23:16], imem_rdata[31:24]};
    assign instr = (`FETCH_BUS_LITTLE) ? rdata_swapped : imem_rdata;

    // Read still goes out and execute raises the exception
    assign mal_insn = (pc[1:0] != 2'b00);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            fetch_ex <= '0;
        end else if (!if_ex_stall) begin
            if (if_ex_flush) begin
                fetch_ex <= '0;
            end else begin
                fetch_ex.valid      <= 1'b1;
                fetch_ex.mal_insn   <= mal_insn;
                fetch_ex.prediction <= predict_taken;
                fetch_ex.pc         <= pc;
                fetch_ex.pc4        <= pc4;
                fetch_ex.instr      <= instr;
            end
        end
    end

endmodule

// ==== branch_predictor.sv ====
`timescale 1ns/1ps
`include "fetch_defines.svh"

module branch_predictor import fetch_pkg::*; (
    input  logic       CLK,
    input  logic       nRST,
    input  word_t      current_pc,
    input  bp_update_t update,
    output logic       predict_taken,
    output word_t      target_addr
);

    logic [`FETCH_BTB_ENTRIES-1:0] entry_valid;
    logic [`FETCH_BTB_ENTRIES-1:0] entry_taken;
    btb_tag_t                      entry_tag [`FETCH_BTB_ENTRIES];
    word_t                         entry_target [`FETCH_BTB_ENTRIES];

    btb_idx_t lookup_idx;
    btb_tag_t lookup_tag;
    btb_idx_t update_idx;
    btb_tag_t update_tag;
    logic     hit;

    // Byte offset bits are not part of the lookup
    assign {lookup_tag, lookup_idx} = current_pc[31:2];
    assign {update_tag, update_idx} = update.update_pc[31:2];

    // Lookup
    assign hit           = entry_valid[lookup_idx] && (entry_tag[lookup_idx] == lookup_tag);
    assign predict_taken = hit && entry_taken[lookup_idx];
    assign target_addr   = entry_target[lookup_idx];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            entry_valid <= '0;
        end else if (update.update_en) begin
            entry_valid[update_idx] <= 1'b1;
        end
    end

    // Entry payload
    always_ff @(posedge CLK) begin
        if (update.update_en) begin
            entry_tag[update_idx]    <= update_tag;
            entry_target[update_idx] <= update.update_target;
            entry_taken[update_idx]  <= update.update_taken;
        end
    end

endmodule

// ==== fetch_control.sv ====
`timescale 1ns/1ps

module fetch_control import fetch_pkg::*; (
    input  logic      CLK,
    input  logic      nRST,
    input  logic      imem_busy,
    input  logic      ex_stall,
    input  redirect_t redirect,
    input  logic      predict_taken,
    output logic      pc_en,
    output logic      iren,
    output logic      if_ex_stall,
    output logic      if_ex_flush
);

    fetch_state_e state;
    fetch_state_e next_state;
    logic         redirect_any;
    logic         fetching;
    logic         take;
    logic         flush_pend;
    logic         pred_bubble;

    assign redirect_any = redirect.insert_priv_pc | redirect.brj_sel;
    assign fetching     = (state == FETCH) || (state == HOLD);

    // Word on the bus belongs to pc and may enter fetch_ex
    assign take = fetching && !imem_busy && !redirect_any && !flush_pend && !pred_bubble;

    assign iren        = fetching;
    assign pc_en       = redirect_any | (take & ~ex_stall);
    assign if_ex_stall = ex_stall;
    // Anything not taken becomes a bubble once execute is free
    assign if_ex_flush = ~take;

    always_comb begin
        next_state = state;
        if (redirect_any) begin
            // Read still in flight for the old address
            if (imem_busy && (state != IDLE_RESET)) begin
                next_state = WAIT_MEM;
            end else if (ex_stall) begin
                next_state = HOLD;
            end else begin
                next_state = FETCH;
            end
        end else begin
            case (state)
                IDLE_RESET: next_state = FETCH;
                FETCH: begin
                    if (ex_stall) begin
                        next_state = HOLD;
                    end
                end
                HOLD: begin
                    if (!ex_stall) begin
                        next_state = FETCH;
                    end
                end
                WAIT_MEM: begin
                    // Stale word arrives with busy low and is dropped
                    if (!imem_busy) begin
                        next_state = ex_stall ? HOLD : FETCH;
                    end
                end
                default: next_state = IDLE_RESET;
            endcase
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state       <= IDLE_RESET;
            flush_pend  <= 1'b0;
            pred_bubble <= 1'b0;
        end else begin
            state       <= next_state;
            // Flush deferred until execute releases the register
            flush_pend  <= ex_stall & (flush_pend | redirect_any);
            // Settling cycle on the target of a taken prediction
            pred_bubble <= take & ~ex_stall & predict_taken;
        end
    end

endmodule

// ==== fetch_pkg.sv ====
`include "fetch_defines.svh"

package fetch_pkg;

    typedef logic [31:0] word_t;

    // BTB index and tag split pc[31:2]
    typedef logic [$clog2(`FETCH_BTB_ENTRIES)-1:0] btb_idx_t;
    typedef logic [29-$clog2(`FETCH_BTB_ENTRIES):0] btb_tag_t;

    // Requests from execute that replace the next pc
    typedef struct packed {
        logic  insert_priv_pc;
        word_t priv_pc;
        logic  brj_sel;
        word_t brj_addr;
    } redirect_t;

    // BTB write from a resolved branch
    typedef struct packed {
        logic  update_en;
        word_t update_pc;
        word_t update_target;
        logic  update_taken;
    } bp_update_t;

    // Fetch to execute pipeline register
    typedef struct packed {
        logic  valid;
        logic  mal_insn;
        logic  prediction;
        word_t pc;
        word_t pc4;
        word_t instr;
    } fetch_ex_t;

    typedef enum logic [1:0] {
        IDLE_RESET,
        FETCH,
        WAIT_MEM,
        HOLD
    } fetch_state_e;

endpackage

// ==== fetch_defines.svh ====
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// First instruction address after reset
`define FETCH_RESET_PC 32'h80000000

// Branch target buffer depth as a power of two
`define FETCH_BTB_ENTRIES 16

// 1 reverses the byte order of instruction words from a little endian bus
`define FETCH_BUS_LITTLE 1'b0

`endif
